// File: verilog/umi_queue_consts.svh
`ifndef UMI_QUEUE_CONSTS_SVH
`define UMI_QUEUE_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// queue geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define UMI_NUM_LANES  2
`define UMI_LANE_DEPTH 4   // packets per lane, power of two

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UMI packet layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define UMI_PKT_W      256

// destination sits in the top 16 bits of the packet
`define UMI_DEST_MSB   255

`endif

// File: verilog/umi_queue_pkg.sv
`default_nettype none

package umi_queue_pkg;

    // destination field, top of every packet
    typedef logic [15:0] dest_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB register map, byte addresses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [7:0] {
        REG_CTRL   = 8'h00, // lane enable bits
        REG_LEVEL  = 8'h04, // fill levels, 4 bits per lane
        REG_COUNT0 = 8'h08, // lane 0 delivered packets
        REG_COUNT1 = 8'h0C  // lane 1 delivered packets
    } reg_addr_e;

    // any write to a counter address clears it

endpackage

`default_nettype wire

// File: verilog/umi_queue_regs.sv
`include "umi_queue_consts.svh"
`default_nettype none

module umi_queue_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [7:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic [4*`UMI_NUM_LANES-1:0] level,
    input  logic [`UMI_NUM_LANES-1:0]   delivered,
    output logic [`UMI_NUM_LANES-1:0]   lane_enable
);

    logic                      access;
    logic                      wr;
    logic                      mapped;
    logic [`UMI_NUM_LANES-1:0] clr;
    logic [31:0]               count_q [`UMI_NUM_LANES];

    assign access = psel && penable;
    assign wr     = access && pwrite;
    assign pready = 1'b1; // no wait states

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (umi_queue_pkg::reg_addr_e'(paddr))
            umi_queue_pkg::REG_CTRL:   prdata[`UMI_NUM_LANES-1:0]   = lane_enable;
            umi_queue_pkg::REG_LEVEL:  prdata[4*`UMI_NUM_LANES-1:0] = level;
            umi_queue_pkg::REG_COUNT0: prdata = count_q[0];
            umi_queue_pkg::REG_COUNT1: prdata = count_q[1];
            default:                   mapped = 1'b0;
        endcase
    end

    assign pslverr = access && !mapped; // unmapped address

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_enable <= '0;
        end else if (wr && paddr == umi_queue_pkg::REG_CTRL) begin
            lane_enable <= pwdata[`UMI_NUM_LANES-1:0];
        end
    end

    assign clr[0] = wr && (paddr == umi_queue_pkg::REG_COUNT0);
    assign clr[1] = wr && (paddr == umi_queue_pkg::REG_COUNT1);

    // delivered-packet counters, clear beats increment
    for (genvar g = 0; g < `UMI_NUM_LANES; g++) begin : g_count
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                count_q[g] <= '0;
            end else if (clr[g]) begin
                count_q[g] <= '0;
            end else if (delivered[g]) begin
                count_q[g] <= count_q[g] + 32'd1;
            end
        end
    end

    // master only raises penable inside a selected transfer
    a_penable_psel: assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> psel
    );

endmodule

`default_nettype wire

// File: verilog/umi_queue_dispatch.sv
`include "umi_queue_consts.svh"
`default_nettype none

module umi_queue_dispatch (
    input  logic [`UMI_PKT_W-1:0]     tx_packet,
    input  logic                      tx_valid,
    output logic                      tx_ready,
    input  logic [`UMI_NUM_LANES-1:0] lane_enable,
    input  logic [`UMI_NUM_LANES-1:0] lane_full,
    output logic [`UMI_NUM_LANES-1:0] push,
    output logic [`UMI_PKT_W-1:0]     push_packet
);

    localparam int SEL_W = $clog2(`UMI_NUM_LANES);

    umi_queue_pkg::dest_t dest;
    logic [SEL_W-1:0]     sel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign dest = tx_packet[`UMI_DEST_MSB -: $bits(umi_queue_pkg::dest_t)];
    assign sel  = SEL_W'(dest % `UMI_NUM_LANES); // destination modulo lane count

    // stall unless the target lane is on and has room
    assign tx_ready = lane_enable[sel] && !lane_full[sel];

    always_comb begin
        push = '0;
        if (tx_valid && tx_ready) begin
            push[sel] = 1'b1;
        end
    end

    // every lane sees the same data and push picks the writer
    assign push_packet = tx_packet;

endmodule

`default_nettype wire

// File: verilog/umi_queue_lane.sv
`include "umi_queue_consts.svh"
`default_nettype none

module umi_queue_lane (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  logic [`UMI_PKT_W-1:0] push_packet,
    input  logic                  pop,
    output logic                  head_valid,
    output logic [`UMI_PKT_W-1:0] head_packet,
    output logic                  full,
    output logic [3:0]            level
);

    localparam int PTR_W = $clog2(`UMI_LANE_DEPTH);

    logic [`UMI_PKT_W-1:0] mem [`UMI_LANE_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [3:0]            count;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_packet;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 4'd1;
                2'b01:   count <= count - 4'd1;
                default: count <= count; // idle or both
            endcase
        end
    end

    assign head_valid  = (count != 4'd0);
    assign head_packet = mem[rd_ptr]; // first-word fall-through
    assign full        = (count == 4'(`UMI_LANE_DEPTH));
    assign level       = count;

    // dispatcher must see full, arbiter must see head_valid
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    );
    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> head_valid
    );

endmodule

`default_nettype wire

// File: verilog/umi_queue_arbiter.sv
`include "umi_queue_consts.svh"
`default_nettype none

module umi_queue_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [`UMI_NUM_LANES-1:0]            head_valid,
    input  logic [`UMI_NUM_LANES*`UMI_PKT_W-1:0] head_packet,
    output logic [`UMI_NUM_LANES-1:0]            pop,
    output logic [`UMI_PKT_W-1:0]                rx_packet,
    output umi_queue_pkg::dest_t                 rx_dest,
    output logic                                 rx_valid,
    input  logic                                 rx_ready,
    output logic [`UMI_NUM_LANES-1:0]            delivered
);

    localparam int SEL_W = $clog2(`UMI_NUM_LANES);

    logic             load;
    logic             any;
    logic [SEL_W-1:0] grant;
    logic [SEL_W-1:0] last; // lane held in the output stage

    assign load = !rx_valid || rx_ready; // output stage free this edge

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // round-robin pick, starting after last
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        int idx;
        any   = 1'b0;
        grant = last;
        for (int i = 1; i <= `UMI_NUM_LANES; i++) begin
            idx = (int'(last) + i) % `UMI_NUM_LANES;
            if (!any && head_valid[idx]) begin
                any   = 1'b1;
                grant = SEL_W'(idx);
            end
        end
    end

    always_comb begin
        pop = '0;
        if (load && any) begin
            pop[grant] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid <= 1'b0;
            last     <= '0;
        end else if (load) begin
            rx_valid <= any;
            if (any) begin
                last <= grant;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && any) begin
            rx_packet <= head_packet[grant*`UMI_PKT_W +: `UMI_PKT_W];
        end
    end

    assign rx_dest = rx_packet[`UMI_DEST_MSB -: $bits(umi_queue_pkg::dest_t)];

    always_comb begin
        delivered = '0;
        if (rx_valid && rx_ready) begin
            delivered[last] = 1'b1;
        end
    end

    a_rx_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rx_valid && !rx_ready |=> rx_valid && $stable(rx_packet)
    );

endmodule

`default_nettype wire

// File: verilog/umi_queues.sv
`include "umi_queue_consts.svh"
`default_nettype none

module umi_queues (
    input  logic                  clk,
    input  logic                  rst_n,
    // transmit stream
    input  logic [`UMI_PKT_W-1:0] tx_packet,
    input  logic                  tx_valid,
    output logic                  tx_ready,
    // receive stream
    output logic [`UMI_PKT_W-1:0] rx_packet,
    output umi_queue_pkg::dest_t  rx_dest,
    output logic                  rx_valid,
    input  logic                  rx_ready,
    // APB registers
    input  logic [7:0]            paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic [`UMI_NUM_LANES-1:0]            lane_enable;
    logic [`UMI_NUM_LANES-1:0]            lane_full;
    logic [`UMI_NUM_LANES-1:0]            push;
    logic [`UMI_PKT_W-1:0]                push_packet;
    logic [`UMI_NUM_LANES-1:0]            head_valid;
    logic [`UMI_NUM_LANES*`UMI_PKT_W-1:0] head_packet;
    logic [`UMI_NUM_LANES-1:0]            pop;
    logic [`UMI_NUM_LANES-1:0]            delivered;
    logic [4*`UMI_NUM_LANES-1:0]          level;

    umi_queue_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .level       (level),
        .delivered   (delivered),
        .lane_enable (lane_enable)
    );

    umi_queue_dispatch u_dispatch (
        .tx_packet   (tx_packet),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .lane_enable (lane_enable),
        .lane_full   (lane_full),
        .push        (push),
        .push_packet (push_packet)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane array
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < `UMI_NUM_LANES; g++) begin : g_lane
        umi_queue_lane u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .push        (push[g]),
            .push_packet (push_packet),
            .pop         (pop[g]),
            .head_valid  (head_valid[g]),
            .head_packet (head_packet[g*`UMI_PKT_W +: `UMI_PKT_W]),
            .full        (lane_full[g]),
            .level       (level[4*g +: 4])
        );
    end

    umi_queue_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .head_valid  (head_valid),
        .head_packet (head_packet),
        .pop         (pop),
        .rx_packet   (rx_packet),
        .rx_dest     (rx_dest),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .delivered   (delivered)
    );

endmodule

`default_nettype wire

// File: bench/umi_queues_tb.sv
`include "umi_queue_consts.svh"
`default_nettype none

module umi_queues_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED    = 32'haa4d;
    localparam int          TIMEOUT = 200; // cycles per wait

    logic                  clk;
    logic                  rst_n;
    logic [`UMI_PKT_W-1:0] tx_packet;
    logic                  tx_valid;
    logic                  tx_ready;
    logic [`UMI_PKT_W-1:0] rx_packet;
    umi_queue_pkg::dest_t  rx_dest;
    logic                  rx_valid;
    logic                  rx_ready;
    logic [7:0]            paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [31:0]           pwdata;
    logic [31:0]           prdata;
    logic                  pready;
    logic                  pslverr;

    logic [63:0]           cases [64];
    logic [`UMI_PKT_W-1:0] rx_q [$];
    umi_queue_pkg::dest_t  dest_q [$];
    int                    rx_cnt [`UMI_NUM_LANES];
    logic [1:0]            rx_mode; // 0 ready, 1 stalled, 2 random
    logic [31:0]           rnd;
    bit                    tx_held; // packet left waiting by check_stall
    int                    errors;
    int                    cur_case;
    string                 cur_name;

    umi_queues UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .tx_packet (tx_packet),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_packet (rx_packet),
        .rx_dest   (rx_dest),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // payload words from xorshift with the destination forced into the top 16 bits
    function automatic logic [`UMI_PKT_W-1:0] make_packet(input umi_queue_pkg::dest_t d,
                                                          input logic [31:0] seed);
        logic [`UMI_PKT_W-1:0] p;
        logic [31:0]           s;
        s = SEED ^ seed;
        for (int k = 0; k < `UMI_PKT_W / 32; k++) begin
            s = xorshift(s);
            p[32*k +: 32] = s;
        end
        p[`UMI_DEST_MSB -: 16] = d;
        return p;
    endfunction

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'd0:    return "apb_write";
            4'd1:    return "apb_read_expect";
            4'd2:    return "send";
            4'd3:    return "expect_rx";
            4'd4:    return "stall_rx";
            4'd5:    return "check_stall";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_mismatch(input logic [255:0] exp, input logic [255:0] act);
        errors++;
        $display("mismatch case %0d %s: expected %0h, actual %0h", cur_case, cur_name, exp, act);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("case %0d %s: %s", cur_case, cur_name, what);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rx_mode == 2'd2) begin
            rnd      <= xorshift(rnd);
            rx_ready <= rnd[0];
        end else begin
            rx_ready <= (rx_mode == 2'd0);
        end
    end

    // handshake completes on the next rising edge
    always @(negedge clk) begin
        if (rst_n && rx_valid && rx_ready) begin
            rx_q.push_back(rx_packet);
            dest_q.push_back(rx_dest);
            rx_cnt[rx_dest % `UMI_NUM_LANES] += 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB and transmit
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apb_access(input logic [7:0] a, input logic w, input logic [31:0] d,
                              output logic [31:0] rd, output logic er);
        int n;
        @(posedge clk);
        paddr   <= a;
        pwrite  <= w;
        pwdata  <= d;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1; // access phase
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pready && n < TIMEOUT);
        assert (pready) else report_failure("timed out waiting for pready");
        rd = prdata;
        er = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] a, input logic [31:0] d);
        logic [31:0] rd;
        logic        er;
        apb_access(a, 1'b1, d, rd, er);
        if (a == umi_queue_pkg::REG_COUNT0) rx_cnt[0] = 0; // write clears
        if (a == umi_queue_pkg::REG_COUNT1) rx_cnt[1] = 0;
    endtask

    task automatic apb_read_expect(input logic [7:0] a, input logic [31:0] exp_data,
                                   input logic exp_err);
        logic [31:0] rd;
        logic        er;
        apb_access(a, 1'b0, 32'd0, rd, er);
        assert (rd == exp_data) else report_mismatch(exp_data, rd);
        assert (er == exp_err) else report_mismatch(exp_err, er);
        // counters also follow the receive monitor
        if (a == umi_queue_pkg::REG_COUNT0) begin
            assert (rd == rx_cnt[0]) else report_mismatch(rx_cnt[0], rd);
        end
        if (a == umi_queue_pkg::REG_COUNT1) begin
            assert (rd == rx_cnt[1]) else report_mismatch(rx_cnt[1], rd);
        end
    endtask

    task automatic send(input umi_queue_pkg::dest_t d, input logic [31:0] seed);
        int n;
        if (!tx_held) begin
            @(posedge clk);
            tx_packet <= make_packet(d, seed);
            tx_valid  <= 1'b1;
        end
        tx_held = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!tx_ready && n < TIMEOUT);
        assert (tx_ready) else report_failure("timed out waiting for tx_ready");
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    // packet stays offered after the check until a later send finishes it
    task automatic check_stall(input umi_queue_pkg::dest_t d, input logic [31:0] seed,
                               input int cycles);
        @(posedge clk);
        tx_packet <= make_packet(d, seed);
        tx_valid  <= 1'b1;
        tx_held = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            assert (!tx_ready) else report_failure("tx_ready rose for a blocked lane");
        end
    endtask

    task automatic expect_rx(input umi_queue_pkg::dest_t d, input logic [31:0] seed);
        logic [`UMI_PKT_W-1:0] exp;
        logic [`UMI_PKT_W-1:0] got;
        umi_queue_pkg::dest_t  got_dest;
        int                    n;
        exp = make_packet(d, seed);
        n = 0;
        while (rx_q.size() == 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (rx_q.size() > 0) else report_failure("timed out waiting for a receive packet");
        if (rx_q.size() > 0) begin
            got      = rx_q.pop_front();
            got_dest = dest_q.pop_front();
            assert (got == exp) else report_mismatch(exp, got);
            assert (got_dest == d) else report_mismatch(d, got_dest);
        end
    endtask

    initial begin
        logic [63:0] c;
        int          err_start;
        clk = 1'b0;
        rst_n = 1'b0;
        tx_packet = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b1;
        paddr = 8'h00;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'd0;
        rx_mode = 2'd0;
        rnd = SEED;
        tx_held = 1'b0;
        errors = 0;
        cur_case = 0;
        cur_name = "load";
        foreach (rx_cnt[i]) rx_cnt[i] = 0;
        foreach (cases[i]) cases[i] = '1; // op f marks the end of the list
        $readmemh("bench/umi_queues_cases.txt", cases);
        assert (cases[0][63:60] != 4'hf) else report_failure("case file could not be read");
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        while (cur_case < 64 && cases[cur_case][63:60] != 4'hf) begin
            c = cases[cur_case];
            cur_name = op_name(c[63:60]);
            err_start = errors;
            case (c[63:60])
                4'd0: apb_write(c[59:52], c[35:4]);
                4'd1: apb_read_expect(c[59:52], c[35:4], c[4'd0]);
                4'd2: send(c[51:36], c[35:4]);
                4'd3: expect_rx(c[51:36], c[35:4]);
                4'd4: begin
                    @(posedge clk);
                    rx_mode <= c[5:4];
                end
                4'd5: check_stall(c[51:36], c[35:4], int'(c[59:52]));
                default: report_failure("unknown operation code in case file");
            endcase
            $display("case %0d %s: %s", cur_case, cur_name, (errors == err_start) ? "ok" : "bad");
            cur_case++;
        end
        cur_name = "end";
        assert (rx_q.size() == 0) else report_failure("extra receive packets left over");
        $display("%0d cases run, %0d errors", cur_case, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/umi_queues_cases.txt
// op_addr_dest_arg_err: op 0 apb_write 1 apb_read_expect 2 send 3 expect_rx 4 stall_rx 5 check_stall
// arg is data, expected value, seed or rx mode (0 ready 1 stall 2 random); check_stall cycles in addr
0_00_0000_00000003_0
1_00_0000_00000003_0
1_10_0000_00000000_1
2_00_0002_00000011_0
2_00_0005_00000012_0
3_00_0002_00000011_0
3_00_0005_00000012_0
0_00_0000_00000001_0
5_14_0007_00000013_0
0_00_0000_00000003_0
2_00_0007_00000013_0
3_00_0007_00000013_0
4_00_0000_00000001_0
2_00_0000_00000020_0
2_00_0002_00000021_0
2_00_0004_00000022_0
2_00_0006_00000023_0
2_00_0008_00000024_0
1_04_0000_00000004_0
5_14_000a_00000025_0
4_00_0000_00000002_0
2_00_000a_00000025_0
3_00_0000_00000020_0
3_00_0002_00000021_0
3_00_0004_00000022_0
3_00_0006_00000023_0
3_00_0008_00000024_0
3_00_000a_00000025_0
1_08_0000_00000007_0
1_0c_0000_00000002_0
0_0c_0000_00000000_0
1_0c_0000_00000000_0
4_00_0000_00000001_0
2_00_0010_00000030_0
2_00_0012_00000031_0
2_00_0011_00000032_0
4_00_0000_00000000_0
3_00_0010_00000030_0
3_00_0011_00000032_0
3_00_0012_00000031_0

// File: project.f
+incdir+verilog
verilog/umi_queue_pkg.sv
verilog/umi_queue_regs.sv
verilog/umi_queue_dispatch.sv
verilog/umi_queue_lane.sv
verilog/umi_queue_arbiter.sv
verilog/umi_queues.sv
bench/umi_queues_tb.sv

// File: Bender.yml
package:
  name: umi_queues

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/umi_queue_pkg.sv
      - verilog/umi_queue_regs.sv
      - verilog/umi_queue_dispatch.sv
      - verilog/umi_queue_lane.sv
      - verilog/umi_queue_arbiter.sv
      - verilog/umi_queues.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/umi_queues_tb.sv
